// ==== source/dcache_pkg.sv ====
package dcache_pkg;

	localparam int num_sets = 8;
	localparam int num_ways = 2;
	localparam int words_per_line = 4;
	localparam int index_bits = 3;
	localparam int offset_bits = 4;
	localparam int tag_bits = 32 - index_bits - offset_bits;

	typedef logic [31:0] word_t;
	typedef logic [3:0] mask_t;
	typedef logic [tag_bits-1:0] tag_t;

	// Word 0 sits in the low 32 bits, matching the byte order of memory
	typedef word_t [words_per_line-1:0] line_t;

	// One registered CPU access of 70 bits
	typedef struct packed {
		logic read;
		logic write;
		logic [31:0] address;
		word_t wdata;
		mask_t mask;
	} cache_req_t;

endpackage

// ==== source/dcache_ctrl_if.sv ====
`timescale 1ns/100ps

interface dcache_ctrl_if;

	// Per-way strobes carry one bit per way
	logic [dcache_pkg::num_ways-1:0] load_data;
	logic [dcache_pkg::num_ways-1:0] load_tag;
	logic [dcache_pkg::num_ways-1:0] set_valid;
	logic [dcache_pkg::num_ways-1:0] set_dirty;
	logic [dcache_pkg::num_ways-1:0] clear_dirty;

	logic load_lru;
	// Line data comes from memory rather than the store merge
	logic fill;
	logic set_rdata;

	modport ctrl (
		output load_data, load_tag, set_valid, set_dirty, clear_dirty,
		output load_lru, fill, set_rdata
	);

	modport array (
		input load_data, load_tag, set_valid, set_dirty, clear_dirty,
		input load_lru, fill, set_rdata
	);

endinterface

// ==== source/dcache_way_ram.sv ====
`timescale 1ns/100ps

module dcache_way_ram #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic [dcache_pkg::index_bits-1:0] index,
	input logic wr_en,
	input payload_t wr_payload,
	output payload_t rd_payload
);

	payload_t mem [dcache_pkg::num_sets];

	// Write lands on the edge, read follows the index in the same cycle
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[index] <= wr_payload;
		end
	end

	assign rd_payload = mem[index];

endmodule

// ==== source/dcache_lookup.sv ====
`timescale 1ns/100ps

module dcache_lookup (
	input logic clk,
	input logic rst_n,
	input logic accept,
	input dcache_pkg::cache_req_t next_req,
	output dcache_pkg::cache_req_t req,
	dcache_ctrl_if.array ctrl,
	output logic hit,
	output logic hit_way,
	output logic victim_way,
	output logic victim_dirty,
	output dcache_pkg::tag_t victim_tag
);

	logic [dcache_pkg::index_bits-1:0] index;
	dcache_pkg::tag_t req_tag;
	dcache_pkg::tag_t way_tag [dcache_pkg::num_ways];
	logic [dcache_pkg::num_ways-1:0] hit_vec;
	logic [dcache_pkg::num_sets-1:0][dcache_pkg::num_ways-1:0] valid;
	logic [dcache_pkg::num_sets-1:0][dcache_pkg::num_ways-1:0] dirty;
	logic [dcache_pkg::num_sets-1:0] lru;
	logic used_way;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req <= '0;
		end else if (accept) begin
			req <= next_req;
		end
	end

	assign index = req.address[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
	assign req_tag = req.address[31 -: dcache_pkg::tag_bits];

	for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : g_tag
		dcache_way_ram #(.payload_t(dcache_pkg::tag_t)) tag_ram (
			.clk(clk),
			.index(index),
			.wr_en(ctrl.load_tag[w]),
			.wr_payload(req_tag),
			.rd_payload(way_tag[w])
		);
		assign hit_vec[w] = valid[index][w] && (way_tag[w] == req_tag);
	end

	assign hit = |hit_vec;
	assign hit_way = hit_vec[1];
	assign victim_way = lru[index];
	assign victim_dirty = valid[index][victim_way] && dirty[index][victim_way];
	assign victim_tag = way_tag[victim_way];

	// During a fill the tag is not yet written, so the victim is the way in use
	assign used_way = hit ? hit_way : victim_way;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
			lru <= '0;
		end else begin
			for (int w = 0; w < dcache_pkg::num_ways; w++) begin
				if (ctrl.set_valid[w])
					valid[index][w] <= 1'b1;
				if (ctrl.set_dirty[w])
					dirty[index][w] <= 1'b1;
				else if (ctrl.clear_dirty[w])
					dirty[index][w] <= 1'b0;
			end
			if (ctrl.load_lru)
				lru[index] <= ~used_way;
		end
	end

	// A tag loaded into the wrong way by control would show up here
	assert property (@(posedge clk) disable iff (!rst_n) !(&hit_vec));

endmodule

// ==== source/dcache_control.sv ====
`timescale 1ns/100ps

module dcache_control (
	input logic clk,
	input logic rst_n,
	input logic next_read,
	input logic next_write,
	input logic resp_ready,
	input logic pmem_resp,
	input logic hit,
	input logic hit_way,
	input logic victim_way,
	input logic victim_dirty,
	input logic req_write,
	output logic accept,
	output logic mem_resp,
	output logic stall_n,
	output logic pmem_read,
	output logic pmem_write,
	output logic pmem_wb_select,
	dcache_ctrl_if.ctrl ctrl
);

	typedef enum logic [2:0] {
		idle,
		lookup,
		write_back,
		fill,
		write_data,
		hold
	} state_t;

	state_t state, next_state;
	logic next_valid;

	assign next_valid = next_read || next_write;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		accept = 1'b0;
		mem_resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;
		pmem_wb_select = 1'b0;
		ctrl.load_data = '0;
		ctrl.load_tag = '0;
		ctrl.set_valid = '0;
		ctrl.set_dirty = '0;
		ctrl.clear_dirty = '0;
		ctrl.load_lru = 1'b0;
		ctrl.fill = 1'b0;
		ctrl.set_rdata = 1'b0;

		unique case (state)
			idle: begin
				accept = next_valid;
				next_state = next_valid ? lookup : idle;
			end
			lookup: begin
				if (hit) begin
					mem_resp = 1'b1;
					ctrl.load_lru = 1'b1;
					ctrl.set_rdata = 1'b1;
					if (req_write) begin
						ctrl.load_data[hit_way] = 1'b1;
						ctrl.set_dirty[hit_way] = 1'b1;
					end
				end else begin
					next_state = victim_dirty ? write_back : fill;
				end
			end
			write_back: begin
				pmem_write = 1'b1;
				pmem_wb_select = 1'b1;
				if (pmem_resp) begin
					ctrl.clear_dirty[victim_way] = 1'b1;
					next_state = fill;
				end
			end
			fill: begin
				pmem_read = 1'b1;
				if (pmem_resp) begin
					ctrl.fill = 1'b1;
					ctrl.load_data[victim_way] = 1'b1;
					ctrl.load_tag[victim_way] = 1'b1;
					ctrl.set_valid[victim_way] = 1'b1;
					if (req_write) begin
						next_state = write_data;
					end else begin
						mem_resp = 1'b1;
						ctrl.load_lru = 1'b1;
						ctrl.set_rdata = 1'b1;
					end
				end
			end
			write_data: begin
				// Merge the store into the line that the fill just wrote
				mem_resp = 1'b1;
				ctrl.load_data[victim_way] = 1'b1;
				ctrl.set_dirty[victim_way] = 1'b1;
				ctrl.load_lru = 1'b1;
			end
			hold: begin
				mem_resp = 1'b1;
			end
			default: next_state = idle;
		endcase

		// Any response either transfers and takes the next access or waits in hold
		if (mem_resp) begin
			if (resp_ready) begin
				accept = next_valid;
				next_state = next_valid ? lookup : idle;
			end else begin
				next_state = hold;
			end
		end
	end

	assign stall_n = (state == idle) || (mem_resp && resp_ready);

	assert property (@(posedge clk) disable iff (!rst_n) !(pmem_read && pmem_write));

	// A refused response moves to hold without taking a new access
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp && !resp_ready |=> (state == hold) && !$past(accept));

endmodule

// ==== source/dcache_data.sv ====
`timescale 1ns/100ps

module dcache_data (
	input logic clk,
	input logic rst_n,
	input dcache_pkg::cache_req_t req,
	input logic [dcache_pkg::index_bits-1:0] index,
	dcache_ctrl_if.array ctrl,
	input logic hit_way,
	input logic victim_way,
	input dcache_pkg::line_t pmem_rdata,
	output dcache_pkg::line_t pmem_wdata,
	output dcache_pkg::word_t rdata,
	input logic hold
);

	dcache_pkg::line_t way_line [dcache_pkg::num_ways];
	dcache_pkg::line_t wr_line [dcache_pkg::num_ways];
	dcache_pkg::line_t src_line;
	dcache_pkg::word_t word_sel;
	dcache_pkg::word_t rdata_q;
	logic [1:0] word_idx;

	assign word_idx = req.address[3:2];

	for (genvar w = 0; w < dcache_pkg::num_ways; w++) begin : g_data
		always_comb begin
			wr_line[w] = ctrl.fill ? pmem_rdata : way_line[w];
			// Byte-masked store merge into the addressed word
			if (!ctrl.fill && req.write) begin
				for (int b = 0; b < 4; b++) begin
					if (req.mask[b])
						wr_line[w][word_idx][8*b +: 8] = req.wdata[8*b +: 8];
				end
			end
		end

		dcache_way_ram #(.payload_t(dcache_pkg::line_t)) line_ram (
			.clk(clk),
			.index(index),
			.wr_en(ctrl.load_data[w]),
			.wr_payload(wr_line[w]),
			.rd_payload(way_line[w])
		);
	end

	assign pmem_wdata = way_line[victim_way];
	assign src_line = ctrl.fill ? pmem_rdata : way_line[hit_way];
	assign word_sel = src_line[word_idx];

	// Keep the word of a refused response, since the line may be overwritten
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rdata_q <= '0;
		else if (ctrl.set_rdata && hold)
			rdata_q <= word_sel;
	end

	assign rdata = ctrl.set_rdata ? word_sel : rdata_q;

endmodule

// ==== source/dcache.sv ====
`timescale 1ns/100ps

module dcache (
	input logic clk,
	input logic rst_n,
	input logic mem_read,
	input logic mem_write,
	input logic [31:0] address,
	input dcache_pkg::word_t wdata,
	input dcache_pkg::mask_t wmask,
	input logic resp_ready,
	output logic mem_resp,
	output dcache_pkg::word_t rdata,
	output logic stall_n,
	output logic pmem_read,
	output logic pmem_write,
	output logic [31:0] pmem_address,
	output dcache_pkg::line_t pmem_wdata,
	input logic pmem_resp,
	input dcache_pkg::line_t pmem_rdata
);

	dcache_pkg::cache_req_t next_req;
	dcache_pkg::cache_req_t req;
	dcache_pkg::tag_t victim_tag;
	logic [dcache_pkg::index_bits-1:0] index;
	logic accept;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic pmem_wb_select;
	logic hold;

	dcache_ctrl_if ctrl_bus ();

	assign next_req = '{read: mem_read, write: mem_write, address: address,
		wdata: wdata, mask: wmask};
	assign index = req.address[dcache_pkg::offset_bits +: dcache_pkg::index_bits];
	assign pmem_address = {pmem_wb_select ? victim_tag : req.address[31 -: dcache_pkg::tag_bits],
		index, {dcache_pkg::offset_bits{1'b0}}};
	assign hold = mem_resp && !resp_ready;

	dcache_lookup u_lookup (
		.clk(clk),
		.rst_n(rst_n),
		.accept(accept),
		.next_req(next_req),
		.req(req),
		.ctrl(ctrl_bus.array),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag)
	);

	dcache_control u_control (
		.clk(clk),
		.rst_n(rst_n),
		.next_read(mem_read),
		.next_write(mem_write),
		.resp_ready(resp_ready),
		.pmem_resp(pmem_resp),
		.hit(hit),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.req_write(req.write),
		.accept(accept),
		.mem_resp(mem_resp),
		.stall_n(stall_n),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_wb_select(pmem_wb_select),
		.ctrl(ctrl_bus.ctrl)
	);

	dcache_data u_data (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.index(index),
		.ctrl(ctrl_bus.array),
		.hit_way(hit_way),
		.victim_way(victim_way),
		.pmem_rdata(pmem_rdata),
		.pmem_wdata(pmem_wdata),
		.rdata(rdata),
		.hold(hold)
	);

endmodule

// ==== test/dcache_mem_model.sv ====
`timescale 1ns/100ps

module dcache_mem_model #(
	parameter int latency = 3,
	parameter int num_lines = 64
) (
	input logic clk,
	input logic rst_n,
	input logic pmem_read,
	input logic pmem_write,
	input logic [31:0] pmem_address,
	input dcache_pkg::line_t pmem_wdata,
	output logic pmem_resp,
	output dcache_pkg::line_t pmem_rdata
);

	// Memory image with one entry per line
	dcache_pkg::line_t mem [num_lines];
	logic [5:0] line_idx;
	int wait_count;
	integer seed;

	assign line_idx = pmem_address[9:4];

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			// Same seed on every reset cycle, so the preload never changes
			seed = 32'h205b_d737;
			for (int i = 0; i < num_lines; i++) begin
				for (int w = 0; w < 4; w++) begin
					mem[i][w] <= $random(seed);
				end
			end
			pmem_resp <= 1'b0;
			pmem_rdata <= '0;
			wait_count <= 0;
		end else begin
			pmem_resp <= 1'b0;
			if ((pmem_read || pmem_write) && !pmem_resp) begin
				if (wait_count == latency - 1) begin
					wait_count <= 0;
					pmem_resp <= 1'b1;
					if (pmem_write)
						mem[line_idx] <= pmem_wdata;
					else
						pmem_rdata <= mem[line_idx];
				end else begin
					wait_count <= wait_count + 1;
				end
			end
		end
	end

endmodule

// ==== test/dcache_tb.sv ====
`timescale 1ns/100ps

module dcache_tb;

	localparam int num_accesses = 300;
	localparam int reset_cycles = 10;
	localparam int mem_lines = 64;
	// A dirty write miss with some refused responses stays within 12 cycles
	localparam int max_cycles = num_accesses * 12 + 100;

	logic clk;
	logic rst_n;
	logic mem_read;
	logic mem_write;
	logic [31:0] address;
	dcache_pkg::word_t wdata;
	dcache_pkg::mask_t wmask;
	logic resp_ready;
	logic mem_resp;
	dcache_pkg::word_t rdata;
	logic stall_n;
	logic pmem_read;
	logic pmem_write;
	logic [31:0] pmem_address;
	dcache_pkg::line_t pmem_wdata;
	logic pmem_resp;
	dcache_pkg::line_t pmem_rdata;

	integer stim_seed;
	int cycles = 0;
	int issued;
	int data_errors;
	int protocol_errors = 0;
	int hold_errors = 0;
	logic first_accept;
	logic nxt_valid;
	logic nxt_repeat;
	logic check_hit;
	logic cur_valid;
	logic cur_write;
	logic [31:0] cur_addr;
	dcache_pkg::word_t cur_wdata;
	dcache_pkg::mask_t cur_mask;
	logic transfer;
	logic take;

	// CPU view of memory by word, and the memory image expected after write-backs
	dcache_pkg::word_t ref_image [mem_lines * 4];
	dcache_pkg::line_t mem_expect [mem_lines];

	dcache uut (.*);

	dcache_mem_model mem_model (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		next_rand = $random(stim_seed);
	endfunction

	task automatic build_preload();
		integer mem_seed;
		dcache_pkg::line_t line;
		mem_seed = 32'h205b_d737;
		for (int i = 0; i < mem_lines; i++) begin
			for (int w = 0; w < 4; w++) begin
				line[w] = $random(mem_seed);
				ref_image[i * 4 + w] = line[w];
			end
			mem_expect[i] = line;
		end
	endtask

	task automatic present_access();
		logic [31:0] rnd;
		rnd = next_rand();
		if (issued == num_accesses) begin
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			nxt_valid = 1'b0;
		end else if (issued > 0 && rnd[1:0] == 2'b00) begin
			// Read the address just accepted once more so that it has to hit
			mem_read <= 1'b1;
			mem_write <= 1'b0;
			nxt_repeat = 1'b1;
			issued++;
		end else begin
			// Bits 8:7 pick one of four tags so that sets keep evicting
			address <= next_rand() & 32'h0000_01fc;
			wdata <= next_rand();
			wmask <= rnd[7:4];
			mem_read <= ~rnd[2];
			mem_write <= rnd[2];
			nxt_repeat = 1'b0;
			issued++;
		end
	endtask

	task automatic finish_access();
		logic [7:0] widx;
		dcache_pkg::word_t exp;
		widx = cur_addr[9:2];
		if (cur_write) begin
			for (int b = 0; b < 4; b++) begin
				if (cur_mask[b])
					ref_image[widx][8*b +: 8] = cur_wdata[8*b +: 8];
			end
		end else begin
			exp = ref_image[widx];
			assert (rdata == exp) else begin
				data_errors++;
				$display("error read_data at %h: expected %h, actual %h", cur_addr, exp, rdata);
			end
		end
	endtask

	task automatic check_write_back();
		logic [5:0] lidx;
		dcache_pkg::line_t exp;
		lidx = pmem_address[9:4];
		for (int w = 0; w < 4; w++) begin
			exp[w] = ref_image[{lidx, w[1:0]}];
		end
		assert (pmem_wdata == exp) else begin
			data_errors++;
			$display("error write_back line %0d: expected %h, actual %h", lidx, exp, pmem_wdata);
		end
		mem_expect[lidx] = exp;
	endtask

	initial begin
		stim_seed = 32'h205b_d737;
		issued = 0;
		data_errors = 0;
		first_accept = 1'b0;
		nxt_valid = 1'b1;
		nxt_repeat = 1'b0;
		check_hit = 1'b0;
		cur_valid = 1'b0;
		rst_n <= 1'b0;
		mem_read <= 1'b0;
		mem_write <= 1'b0;
		address <= '0;
		wdata <= '0;
		wmask <= '0;
		resp_ready <= 1'b1;
		build_preload();
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
		present_access();
		while (nxt_valid || cur_valid) begin
			@(negedge clk);
			transfer = mem_resp && resp_ready;
			take = stall_n && nxt_valid;
			if (check_hit) begin
				assert (mem_resp && !pmem_read) else begin
					data_errors++;
					$display("error repeat_hit at %h: expected mem_resp 1 pmem_read 0, actual %b %b",
						cur_addr, mem_resp, pmem_read);
				end
				check_hit = 1'b0;
			end
			if (pmem_write && pmem_resp)
				check_write_back();
			assert (!mem_resp || cur_valid) else begin
				data_errors++;
				$display("mem_resp went high with no access outstanding at %0t", $time);
			end
			if (transfer && cur_valid)
				finish_access();
			@(posedge clk);
			if (transfer)
				cur_valid = 1'b0;
			if (take) begin
				cur_valid = 1'b1;
				cur_write = mem_write;
				cur_addr = address;
				cur_wdata = wdata;
				cur_mask = wmask;
				check_hit = nxt_repeat;
				first_accept = 1'b1;
				present_access();
			end
			resp_ready <= (next_rand() % 10) < 7;
		end
		// Lines that were never written back must still hold their preload
		for (int i = 0; i < mem_lines; i++) begin
			assert (mem_model.mem[i] == mem_expect[i]) else begin
				data_errors++;
				$display("error memory_image line %0d: expected %h, actual %h",
					i, mem_expect[i], mem_model.mem[i]);
			end
		end
		$display("accesses %0d, errors: data %0d, protocol %0d, hold %0d",
			issued, data_errors, protocol_errors, hold_errors);
		if (data_errors + protocol_errors + hold_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	always @(negedge clk) begin
		assert (!(pmem_read && pmem_write)) else begin
			protocol_errors++;
			$display("pmem_read and pmem_write are high together at %0t", $time);
		end
		assert (first_accept || !(pmem_read || pmem_write || mem_resp)) else begin
			protocol_errors++;
			$display("memory or response strobe active before the first access at %0t", $time);
		end
	end

	// A refused response keeps mem_resp and rdata and lets no access in
	assert property (@(posedge clk) disable iff (!rst_n)
		mem_resp && !resp_ready |=> mem_resp && $stable(rdata) && !$past(stall_n))
	else begin
		hold_errors++;
		$display("response changed or access taken while resp_ready was low at %0t", $time);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles with %0d accesses issued", cycles, issued);
			$display("TB FAILED");
			$finish;
		end
	end

endmodule

// ==== dcache.f ====
source/dcache_pkg.sv
source/dcache_ctrl_if.sv
source/dcache_way_ram.sv
source/dcache_lookup.sv
source/dcache_control.sv
source/dcache_data.sv
source/dcache.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// ==== Makefile ====
SOURCES = $(wildcard source/*.sv test/*.sv)

.PHONY: run clean

run: obj_dir/Vdcache_tb
	@out=$$(obj_dir/Vdcache_tb); echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

obj_dir/Vdcache_tb: dcache.f $(SOURCES)
	verilator --binary --timing --assert --top-module dcache_tb -f dcache.f

clean:
	rm -rf obj_dir
